/* source/opnd_decode_defs.svh */
`ifndef OPND_DECODE_DEFS_SVH
`define OPND_DECODE_DEFS_SVH

// Entries per inner link, also the source's starting credits
`define OPND_LINK_DEPTH 2

// Response slots on the consumer side
`define OPND_OUT_CREDITS 4

// Instruction bytes per request, escapes already removed
`define OPND_INSTR_BYTES 11

`endif

/* source/x86_isa_pkg.sv */
package x86_isa_pkg;

  // Register number, encoding order of the 32-bit GPRs
  typedef logic [2:0] reg_sel_t;

  localparam reg_sel_t REG_EAX = 3'd0;
  localparam reg_sel_t REG_ECX = 3'd1;
  localparam reg_sel_t REG_EDX = 3'd2;
  localparam reg_sel_t REG_EBX = 3'd3;
  localparam reg_sel_t REG_ESP = 3'd4;
  localparam reg_sel_t REG_EBP = 3'd5;
  localparam reg_sel_t REG_ESI = 3'd6;
  localparam reg_sel_t REG_EDI = 3'd7;

  // Snapshot of all eight GPRs, indexed by reg_sel_t
  typedef logic [7:0][31:0] reg_file_t;

  typedef struct packed {
    logic [1:0] mod;
    logic [2:0] regop;
    logic [2:0] rm;
  } modrm_t;

  typedef struct packed {
    logic [1:0] scale;
    logic [2:0] index;
    logic [2:0] base;
  } sib_t;

  // Command classes; only the string commands matter to operand decode
  typedef enum logic [5:0] {
    CMD_OTHER = 6'd0,
    CMD_MOVS  = 6'd1,
    CMD_CMPS  = 6'd2,
    CMD_STOS  = 6'd3,
    CMD_LODS  = 6'd4,
    CMD_SCAS  = 6'd5
  } cmd_t;

  typedef enum logic [3:0] {
    FORM_NONE    = 4'd0,
    FORM_REG     = 4'd1,
    FORM_REG_IMM = 4'd2,
    FORM_EAX_IMM = 4'd3,
    FORM_EAX_REG = 4'd4,
    FORM_RM      = 4'd5,
    FORM_RM_REG  = 4'd6,
    FORM_REG_RM  = 4'd7,
    FORM_RM_IMM  = 4'd8
  } opnd_form_t;

  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_kind_t;

endpackage

/* source/opnd_pipe_pkg.sv */
`include "opnd_decode_defs.svh"

package opnd_pipe_pkg;

  import x86_isa_pkg::*;

  // Byte 0 is the opcode, ModR/M follows when present
  typedef logic [`OPND_INSTR_BYTES-1:0][7:0] instr_t;

  typedef struct packed {
    logic        is_write;
    logic [31:0] address;
    logic [31:0] data;
  } mem_hint_t;

  typedef struct packed {
    instr_t         instr;
    cmd_t           cmd;
    opnd_form_t     form;
    logic           imm_1byte;
    logic           op0_rd;
    logic           op0_wr;
    logic           op1_rd;
    logic           op1_wr;
    reg_file_t      regs;
    mem_hint_t [1:0] hints;
  } opnd_req_t;

  // Stage 1 result
  typedef struct packed {
    modrm_t          modrm;
    sib_t            sib;
    logic            has_sib;
    logic [31:0]     disp;
    logic [31:0]     imm;
    reg_sel_t        opc_low;
    // Operand roles from the form
    logic            rm_direct;
    logic            op0_rm;
    logic            op0_reg;
    logic            op1_rm;
    logic            op1_reg;
    // Carried on from the request
    cmd_t            cmd;
    opnd_form_t      form;
    logic            op0_wr;
    logic            op1_wr;
    reg_file_t       regs;
    mem_hint_t [1:0] hints;
  } fields_t;

  // Per operand sources, ready for the AGU
  typedef struct packed {
    logic        is_reg;
    logic        is_mem;
    logic        is_imm;
    logic [31:0] reg_val;
    reg_sel_t    reg_sel;
    logic [31:0] base;
    logic [31:0] index;
    logic [1:0]  scale;
    logic [31:0] disp;
  } opnd_src_t;

  // Stage 2 result
  typedef struct packed {
    opnd_src_t       op0;
    opnd_src_t       op1;
    logic [31:0]     imm;
    logic            op0_wr;
    logic            op1_wr;
    mem_hint_t [1:0] hints;
  } sources_t;

  typedef struct packed {
    logic [31:0] opnd0;
    logic [31:0] opnd1;
    dest_kind_t  dest0_kind;
    reg_sel_t    dest0_sel;
    dest_kind_t  dest1_kind;
    reg_sel_t    dest1_sel;
  } opnd_resp_t;

endpackage

/* source/opnd_link.sv */
`timescale 1ns/1ps

module opnd_link #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     can_push,
  input  logic     pop,
  output payload_t head,
  output logic     head_valid,
  output logic     credit
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  // Sender side credits
  logic [CW-1:0]   cred;

  // Storage only, the pointers say what is live
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      cred   <= CW'(DEPTH);
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(push) - CW'(pop);
      // Credit comes back a cycle after the slot frees
      credit <= pop;
      cred   <= cred - CW'(push) + CW'(credit);
    end
  end

  assign can_push   = (cred != '0);
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

endmodule

/* source/opnd_field_extract.sv */
`timescale 1ns/1ps

module opnd_field_extract (
  input  logic                     clk,
  input  logic                     arst_n,
  input  opnd_pipe_pkg::opnd_req_t in_head,
  input  logic                     in_valid,
  output logic                     in_pop,
  output logic                     out_push,
  output opnd_pipe_pkg::fields_t   out_data,
  input  logic                     out_can_push
);

  import x86_isa_pkg::*;
  import opnd_pipe_pkg::*;

  logic        has_modrm;
  logic        has_imm;
  logic        has_sib;
  logic        disp8;
  logic        disp32;
  modrm_t      modrm;
  sib_t        sib;
  logic [3:0]  disp_off;
  logic [3:0]  imm_off;
  logic [31:0] disp;
  logic [31:0] imm;

  // Little-endian word starting at byte off
  function automatic logic [31:0] word_at(input instr_t instr, input logic [3:0] off);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = instr[off + 4'(i)];
    end
    return w;
  endfunction

  // Form alone says whether ModR/M and an immediate exist
  assign has_modrm = in_head.form inside {FORM_RM, FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};
  assign has_imm   = in_head.form inside {FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM};

  assign modrm   = has_modrm ? modrm_t'(in_head.instr[1]) : '0;
  // rm 100 escapes to SIB, except in register direct mode
  assign has_sib = has_modrm && modrm.mod != 2'b11 && modrm.rm == 3'b100;
  assign sib     = has_sib ? sib_t'(in_head.instr[2]) : '0;

  assign disp8  = modrm.mod == 2'b01;
  assign disp32 = modrm.mod == 2'b10 ||
                  (modrm.mod == 2'b00 &&
                   (modrm.rm == 3'b101 || (has_sib && sib.base == 3'b101)));

  // Displacement sits after opcode, ModR/M and SIB
  assign disp_off = 4'd1 + {3'b0, has_modrm} + {3'b0, has_sib};
  assign imm_off  = disp_off + (disp32 ? 4'd4 : disp8 ? 4'd1 : 4'd0);

  always_comb begin
    if (disp32) begin
      disp = word_at(in_head.instr, disp_off);
    end else if (disp8) begin
      disp = {{24{in_head.instr[disp_off][7]}}, in_head.instr[disp_off]};
    end else begin
      disp = '0;
    end
  end

  always_comb begin
    if (!has_imm) begin
      imm = '0;
    end else if (in_head.imm_1byte) begin
      imm = {{24{in_head.instr[imm_off][7]}}, in_head.instr[imm_off]};
    end else begin
      imm = word_at(in_head.instr, imm_off);
    end
  end

  always_comb begin
    out_data           = '0;
    out_data.modrm     = modrm;
    out_data.sib       = sib;
    out_data.has_sib   = has_sib;
    out_data.disp      = disp;
    out_data.imm       = imm;
    // Short register forms encode the register in the opcode
    out_data.opc_low   = in_head.instr[0][2:0];
    out_data.rm_direct = has_modrm && modrm.mod == 2'b11;
    out_data.op0_rm    = in_head.form inside {FORM_RM, FORM_RM_REG, FORM_RM_IMM};
    out_data.op0_reg   = in_head.form == FORM_REG_RM;
    out_data.op1_rm    = in_head.form == FORM_REG_RM;
    out_data.op1_reg   = in_head.form == FORM_RM_REG;
    out_data.cmd       = in_head.cmd;
    out_data.form      = in_head.form;
    out_data.op0_wr    = in_head.op0_wr;
    out_data.op1_wr    = in_head.op1_wr;
    out_data.regs      = in_head.regs;
    out_data.hints     = in_head.hints;
  end

  // Move one request per cycle when the next link has room
  assign in_pop   = in_valid && out_can_push;
  assign out_push = in_pop;

endmodule

/* source/opnd_source_select.sv */
`timescale 1ns/1ps

module opnd_source_select (
  input  logic                    clk,
  input  logic                    arst_n,
  input  opnd_pipe_pkg::fields_t  in_head,
  input  logic                    in_valid,
  output logic                    in_pop,
  output logic                    out_push,
  output opnd_pipe_pkg::sources_t out_data,
  input  logic                    out_can_push
);

  import x86_isa_pkg::*;
  import opnd_pipe_pkg::*;

  logic      op0_rm_mem;
  logic      op1_rm_mem;
  logic      op0_str;
  logic      op1_str;
  reg_sel_t  op0_str_sel;
  reg_sel_t  op1_str_sel;
  opnd_src_t op0;
  opnd_src_t op1;

  // Base, index, scale and displacement of one operand
  function automatic opnd_src_t addr_src(input fields_t f, input logic rm_mem,
                                         input logic implicit, input reg_sel_t imp_sel);
    opnd_src_t s;
    reg_sel_t  base_sel;
    logic      no_base;
    s        = '0;
    base_sel = f.has_sib ? f.sib.base : f.modrm.rm;
    // mod 00 with base 101 means disp32 only, no base register
    no_base  = f.modrm.mod == 2'b00 && base_sel == 3'b101;
    if (implicit) begin
      s.base = f.regs[imp_sel];
    end else if (rm_mem && !no_base) begin
      s.base = f.regs[base_sel];
    end
    if (rm_mem && f.has_sib) begin
      s.scale = f.sib.scale;
      // Index 100 in SIB means no index
      if (f.sib.index != 3'b100) begin
        s.index = f.regs[f.sib.index];
      end
    end
    if (rm_mem) begin
      s.disp = f.disp;
    end
    return s;
  endfunction

  assign op0_rm_mem = in_head.op0_rm && !in_head.rm_direct;
  assign op1_rm_mem = in_head.op1_rm && !in_head.rm_direct;

  // String commands address through ESI and EDI
  assign op0_str     = in_head.cmd inside {CMD_MOVS, CMD_CMPS, CMD_STOS, CMD_SCAS};
  assign op0_str_sel = (in_head.cmd == CMD_CMPS) ? REG_ESI : REG_EDI;
  assign op1_str     = in_head.cmd inside {CMD_MOVS, CMD_CMPS, CMD_LODS};
  assign op1_str_sel = (in_head.cmd == CMD_CMPS) ? REG_EDI : REG_ESI;

  always_comb begin
    op0        = addr_src(in_head, op0_rm_mem, op0_str, op0_str_sel);
    op0.is_mem = op0_rm_mem || in_head.cmd inside {CMD_MOVS, CMD_CMPS, CMD_SCAS};
    op0.is_imm = 1'b0;
    op0.is_reg = in_head.form inside {FORM_REG, FORM_REG_IMM, FORM_EAX_IMM, FORM_EAX_REG} ||
                 (in_head.op0_rm && in_head.rm_direct) || in_head.op0_reg;
    if (in_head.form inside {FORM_REG, FORM_REG_IMM}) begin
      op0.reg_sel = in_head.opc_low;
    end else if (in_head.op0_rm && in_head.rm_direct) begin
      op0.reg_sel = in_head.modrm.rm;
    end else if (in_head.op0_reg) begin
      op0.reg_sel = in_head.modrm.regop;
    end else begin
      // EAX forms, and a harmless zero otherwise
      op0.reg_sel = REG_EAX;
    end
    op0.reg_val = in_head.regs[op0.reg_sel];
  end

  always_comb begin
    op1        = addr_src(in_head, op1_rm_mem, op1_str, op1_str_sel);
    op1.is_mem = op1_rm_mem || in_head.cmd inside {CMD_MOVS, CMD_CMPS, CMD_STOS, CMD_LODS};
    op1.is_imm = in_head.form inside {FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM};
    op1.is_reg = in_head.form == FORM_EAX_REG ||
                 (in_head.op1_rm && in_head.rm_direct) || in_head.op1_reg;
    if (in_head.op1_rm && in_head.rm_direct) begin
      op1.reg_sel = in_head.modrm.rm;
    end else if (in_head.op1_reg) begin
      op1.reg_sel = in_head.modrm.regop;
    end else if (in_head.form == FORM_EAX_REG) begin
      op1.reg_sel = in_head.opc_low;
    end else begin
      op1.reg_sel = REG_EAX;
    end
    op1.reg_val = in_head.regs[op1.reg_sel];
  end

  always_comb begin
    out_data        = '0;
    out_data.op0    = op0;
    out_data.op1    = op1;
    out_data.imm    = in_head.imm;
    out_data.op0_wr = in_head.op0_wr;
    out_data.op1_wr = in_head.op1_wr;
    out_data.hints  = in_head.hints;
  end

  assign in_pop   = in_valid && out_can_push;
  assign out_push = in_pop;

endmodule

/* source/opnd_addr_resolve.sv */
`timescale 1ns/1ps
`include "opnd_decode_defs.svh"

module opnd_addr_resolve (
  input  logic                      clk,
  input  logic                      arst_n,
  input  opnd_pipe_pkg::sources_t   in_head,
  input  logic                      in_valid,
  output logic                      in_pop,
  output logic                      out_valid,
  output opnd_pipe_pkg::opnd_resp_t out_resp,
  input  logic                      out_credit
);

  import x86_isa_pkg::*;
  import opnd_pipe_pkg::*;

  localparam int CW = $clog2(`OPND_OUT_CREDITS + 1);

  logic [CW-1:0] cred;
  opnd_resp_t    resp;

  // AGU, then hint lookup; hint 0 wins, writes never supply data
  function automatic logic [31:0] opnd_value(input opnd_src_t s, input logic [31:0] imm,
                                             input mem_hint_t [1:0] hints);
    logic [31:0] addr;
    logic [31:0] mem_val;
    addr    = s.base + (s.index << s.scale) + s.disp;
    mem_val = '0;
    if (!hints[0].is_write && hints[0].address == addr) begin
      mem_val = hints[0].data;
    end else if (!hints[1].is_write && hints[1].address == addr) begin
      mem_val = hints[1].data;
    end
    if (s.is_reg) begin
      return s.reg_val;
    end else if (s.is_mem) begin
      return mem_val;
    end else if (s.is_imm) begin
      return imm;
    end
    return '0;
  endfunction

  function automatic dest_kind_t dest_kind(input opnd_src_t s, input logic wr);
    if (!wr) begin
      return DEST_NONE;
    end
    return s.is_reg ? DEST_REG : s.is_mem ? DEST_MEM : DEST_NONE;
  endfunction

  always_comb begin
    resp.opnd0      = opnd_value(in_head.op0, in_head.imm, in_head.hints);
    resp.opnd1      = opnd_value(in_head.op1, in_head.imm, in_head.hints);
    resp.dest0_kind = dest_kind(in_head.op0, in_head.op0_wr);
    resp.dest1_kind = dest_kind(in_head.op1, in_head.op1_wr);
    // Selector only means something for register destinations
    resp.dest0_sel  = (resp.dest0_kind == DEST_REG) ? in_head.op0.reg_sel : '0;
    resp.dest1_sel  = (resp.dest1_kind == DEST_REG) ? in_head.op1.reg_sel : '0;
  end

  // Hold the head while the consumer has no free slot
  assign in_pop = in_valid && (cred != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      cred      <= CW'(`OPND_OUT_CREDITS);
    end else begin
      out_valid <= in_pop;
      cred      <= cred - CW'(in_pop) + CW'(out_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (in_pop) begin
      out_resp <= resp;
    end
  end

endmodule

/* source/opnd_decode_top.sv */
`timescale 1ns/1ps
`include "opnd_decode_defs.svh"

module opnd_decode_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,
  input  opnd_pipe_pkg::opnd_req_t  in_req,
  output logic                      in_credit,
  output logic                      out_valid,
  output opnd_pipe_pkg::opnd_resp_t out_resp,
  input  logic                      out_credit
);

  import opnd_pipe_pkg::*;

  // Request link, its credit pulse goes back to the source
  opnd_req_t req_head;
  logic      req_valid;
  logic      req_pop;

  // Stage 1 to stage 2
  fields_t   fld_data;
  fields_t   fld_head;
  logic      fld_push;
  logic      fld_can_push;
  logic      fld_valid;
  logic      fld_pop;

  // Stage 2 to stage 3
  sources_t  src_data;
  sources_t  src_head;
  logic      src_push;
  logic      src_can_push;
  logic      src_valid;
  logic      src_pop;

  opnd_link #(.payload_t(opnd_req_t), .DEPTH(`OPND_LINK_DEPTH)) u_req_link (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (in_valid),
    .push_data  (in_req),
    .can_push   (),
    .pop        (req_pop),
    .head       (req_head),
    .head_valid (req_valid),
    .credit     (in_credit)
  );

  opnd_field_extract u_extract (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_head      (req_head),
    .in_valid     (req_valid),
    .in_pop       (req_pop),
    .out_push     (fld_push),
    .out_data     (fld_data),
    .out_can_push (fld_can_push)
  );

  opnd_link #(.payload_t(fields_t), .DEPTH(`OPND_LINK_DEPTH)) u_fld_link (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (fld_push),
    .push_data  (fld_data),
    .can_push   (fld_can_push),
    .pop        (fld_pop),
    .head       (fld_head),
    .head_valid (fld_valid),
    .credit     ()
  );

  opnd_source_select u_select (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_head      (fld_head),
    .in_valid     (fld_valid),
    .in_pop       (fld_pop),
    .out_push     (src_push),
    .out_data     (src_data),
    .out_can_push (src_can_push)
  );

  opnd_link #(.payload_t(sources_t), .DEPTH(`OPND_LINK_DEPTH)) u_src_link (
    .clk        (clk),
    .arst_n     (arst_n),
    .push       (src_push),
    .push_data  (src_data),
    .can_push   (src_can_push),
    .pop        (src_pop),
    .head       (src_head),
    .head_valid (src_valid),
    .credit     ()
  );

  opnd_addr_resolve u_resolve (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_head    (src_head),
    .in_valid   (src_valid),
    .in_pop     (src_pop),
    .out_valid  (out_valid),
    .out_resp   (out_resp),
    .out_credit (out_credit)
  );

endmodule

/* dv/opnd_ref_model.svh */
`ifndef OPND_REF_MODEL_SVH
`define OPND_REF_MODEL_SVH

// What the model knows about one operand
typedef struct packed {
  logic        is_reg;
  logic        is_mem;
  logic        is_imm;
  reg_sel_t    sel;
  logic [31:0] addr;
  logic [31:0] imm;
} opnd_view_t;

// Four instruction bytes, least significant first
function automatic logic [31:0] le_word(input opnd_req_t r, input int pos);
  return {r.instr[pos+3], r.instr[pos+2], r.instr[pos+1], r.instr[pos]};
endfunction

// Decode operand 0 or operand 1 straight from the encoding rules
function automatic opnd_view_t view_of(input opnd_req_t r, input bit second);
  opnd_view_t  v;
  modrm_t      m;
  sib_t        s;
  logic        rm_form;
  logic        sib_on;
  logic        uses_rm;
  logic        uses_reg;
  logic        rm_mem;
  logic        str_base;
  reg_sel_t    str_reg;
  reg_sel_t    base_sel;
  logic [31:0] base;
  logic [31:0] index;
  logic [31:0] disp;
  int          pos;
  v       = '0;
  rm_form = r.form inside {FORM_RM, FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};
  m       = rm_form ? modrm_t'(r.instr[1]) : '0;
  sib_on  = rm_form && m.mod != 2'b11 && m.rm == 3'b100;
  s       = sib_on ? sib_t'(r.instr[2]) : '0;
  pos     = 1 + int'(rm_form) + int'(sib_on);
  // Displacement first, the immediate sits right behind it
  disp = '0;
  if (m.mod == 2'b01) begin
    disp = {{24{r.instr[pos][7]}}, r.instr[pos]};
    pos  = pos + 1;
  end else if (m.mod == 2'b10 ||
               (m.mod == 2'b00 && (m.rm == 3'b101 || (sib_on && s.base == 3'b101)))) begin
    disp = le_word(r, pos);
    pos  = pos + 4;
  end
  if (r.imm_1byte) begin
    v.imm = {{24{r.instr[pos][7]}}, r.instr[pos]};
  end else begin
    v.imm = le_word(r, pos);
  end
  v.is_imm = second && r.form inside {FORM_REG_IMM, FORM_EAX_IMM, FORM_RM_IMM};
  uses_rm  = second ? r.form == FORM_REG_RM : r.form inside {FORM_RM, FORM_RM_REG, FORM_RM_IMM};
  uses_reg = second ? r.form == FORM_RM_REG : r.form == FORM_REG_RM;
  rm_mem   = uses_rm && m.mod != 2'b11;
  // Register operand and where its number comes from
  v.is_reg = 1'b1;
  if (!second && r.form inside {FORM_REG, FORM_REG_IMM}) begin
    v.sel = r.instr[0][2:0];
  end else if (uses_rm && !rm_mem) begin
    v.sel = m.rm;
  end else if (uses_reg) begin
    v.sel = m.regop;
  end else if (!second && r.form inside {FORM_EAX_IMM, FORM_EAX_REG}) begin
    v.sel = REG_EAX;
  end else if (second && r.form == FORM_EAX_REG) begin
    v.sel = r.instr[0][2:0];
  end else begin
    v.is_reg = 1'b0;
  end
  // String commands walk ESI and EDI
  if (second) begin
    v.is_mem = rm_mem || r.cmd inside {CMD_MOVS, CMD_CMPS, CMD_STOS, CMD_LODS};
    str_base = r.cmd inside {CMD_MOVS, CMD_CMPS, CMD_LODS};
    str_reg  = (r.cmd == CMD_CMPS) ? REG_EDI : REG_ESI;
  end else begin
    v.is_mem = rm_mem || r.cmd inside {CMD_MOVS, CMD_CMPS, CMD_SCAS};
    str_base = r.cmd inside {CMD_MOVS, CMD_CMPS, CMD_STOS, CMD_SCAS};
    str_reg  = (r.cmd == CMD_CMPS) ? REG_ESI : REG_EDI;
  end
  base_sel = sib_on ? s.base : m.rm;
  base     = '0;
  index    = '0;
  if (str_base) begin
    base = r.regs[str_reg];
  end else if (rm_mem && !(m.mod == 2'b00 && base_sel == 3'b101)) begin
    base = r.regs[base_sel];
  end
  // Index 100 means no index
  if (rm_mem && sib_on && s.index != 3'b100) begin
    index = r.regs[s.index] << s.scale;
  end
  v.addr = base + index + (rm_mem ? disp : 32'd0);
  return v;
endfunction

// Priority is register, memory, immediate
function automatic logic [31:0] value_of(input opnd_req_t r, input opnd_view_t v);
  if (v.is_reg) begin
    return r.regs[v.sel];
  end
  if (v.is_mem) begin
    for (int h = 0; h < 2; h++) begin
      if (!r.hints[h].is_write && r.hints[h].address == v.addr) begin
        return r.hints[h].data;
      end
    end
    return '0;
  end
  return v.is_imm ? v.imm : 32'd0;
endfunction

function automatic dest_kind_t kind_of(input opnd_view_t v, input logic wr);
  if (!wr) begin
    return DEST_NONE;
  end
  if (v.is_reg) begin
    return DEST_REG;
  end
  return v.is_mem ? DEST_MEM : DEST_NONE;
endfunction

function automatic opnd_resp_t expect_resp(input opnd_req_t r);
  opnd_view_t v0;
  opnd_view_t v1;
  opnd_resp_t e;
  v0           = view_of(r, 1'b0);
  v1           = view_of(r, 1'b1);
  e.opnd0      = value_of(r, v0);
  e.opnd1      = value_of(r, v1);
  e.dest0_kind = kind_of(v0, r.op0_wr);
  e.dest1_kind = kind_of(v1, r.op1_wr);
  e.dest0_sel  = (e.dest0_kind == DEST_REG) ? v0.sel : 3'd0;
  e.dest1_sel  = (e.dest1_kind == DEST_REG) ? v1.sel : 3'd0;
  return e;
endfunction

// Random legal request, hints often aimed at a real operand address
function automatic opnd_req_t gen_request();
  opnd_req_t  r;
  opnd_view_t v;
  int         pick;
  r = '0;
  for (int i = 0; i < `OPND_INSTR_BYTES; i++) begin
    r.instr[i] = 8'(rand32());
  end
  for (int i = 0; i < 8; i++) begin
    r.regs[i] = rand32();
  end
  r.form = opnd_form_t'(4'(rand32() % 9));
  // Mostly plain commands, each string command now and then
  pick  = int'(rand32() % 12);
  r.cmd = (pick <= 5) ? cmd_t'(6'(pick)) : CMD_OTHER;
  r.imm_1byte = 1'(rand32());
  {r.op0_rd, r.op0_wr, r.op1_rd, r.op1_wr} = 4'(rand32());
  for (int h = 0; h < 2; h++) begin
    r.hints[h].is_write = (rand32() % 4) == 0;
    r.hints[h].address  = rand32();
    r.hints[h].data     = rand32();
    if (rand32() % 2 == 1) begin
      v = view_of(r, 1'(rand32()));
      r.hints[h].address = v.addr;
    end
  end
  return r;
endfunction

`endif

/* dv/tb_opnd_decode.sv */
`timescale 1ns/1ps
`include "opnd_decode_defs.svh"

module tb_opnd_decode;

  import x86_isa_pkg::*;
  import opnd_pipe_pkg::*;

  localparam int NUM_REQ    = 300;
  localparam int MAX_CYCLES = 20000;

  logic       clk;
  logic       arst_n;
  logic       in_valid;
  opnd_req_t  in_req;
  logic       in_credit;
  logic       out_valid;
  opnd_resp_t out_resp;
  logic       out_credit;

  // LCG state, stepped by every draw
  logic [31:0] lcg_state = 32'hb55b;
  int          mismatches;
  int          failures;
  int          sent;
  int          received;
  // Source credits and consumer free slots
  int          tx_credits;
  int          free_slots;
  int          cycles;
  opnd_resp_t  expected [$];

  // Two LCG steps, upper halves only since low bits repeat fast
  function automatic logic [31:0] rand32();
    logic [31:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi        = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi[31:16], lcg_state[31:16]};
  endfunction

  `include "opnd_ref_model.svh"

  opnd_decode_top DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_resp   (out_resp),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_kind(input string name, input dest_kind_t got, input dest_kind_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_resp(input opnd_resp_t exp);
    check_word("opnd0", out_resp.opnd0, exp.opnd0);
    check_word("opnd1", out_resp.opnd1, exp.opnd1);
    check_kind("dest0_kind", out_resp.dest0_kind, exp.dest0_kind);
    check_sel("dest0_sel", out_resp.dest0_sel, exp.dest0_sel);
    check_kind("dest1_kind", out_resp.dest1_kind, exp.dest1_kind);
    check_sel("dest1_sel", out_resp.dest1_sel, exp.dest1_sel);
  endtask

  // One clock of scoreboard, consumer and driver, 1 ns after the edge
  task automatic run_cycle();
    opnd_resp_t exp;
    @(posedge clk);
    #1;
    if (in_credit) begin
      tx_credits++;
      if (tx_credits > `OPND_LINK_DEPTH) begin
        failures++;
        $display("at %0t in_credit raised the source credits above the link depth", $time);
      end
    end
    if (out_valid) begin
      if (free_slots == 0) begin
        failures++;
        $display("at %0t a response arrived while the consumer had no free slot", $time);
      end else begin
        free_slots--;
      end
      if (expected.size() == 0) begin
        failures++;
        $display("at %0t a response arrived with no request outstanding", $time);
      end else begin
        exp = expected.pop_front();
        compare_resp(exp);
        received++;
      end
    end
    // Consumer drains a slot at random
    out_credit = 1'b0;
    if (free_slots < `OPND_OUT_CREDITS && rand32() % 3 == 0) begin
      out_credit = 1'b1;
      free_slots++;
    end
    in_valid = 1'b0;
    if (sent < NUM_REQ && tx_credits > 0 && rand32() % 4 != 0) begin
      in_req = gen_request();
      expected.push_back(expect_resp(in_req));
      in_valid = 1'b1;
      tx_credits--;
      sent++;
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_req     = '0;
    out_credit = 1'b0;
    mismatches = 0;
    failures   = 0;
    sent       = 0;
    received   = 0;
    tx_credits = `OPND_LINK_DEPTH;
    free_slots = `OPND_OUT_CREDITS;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    if (out_valid || in_credit) begin
      failures++;
      $display("out_valid or in_credit is high right after reset");
    end
    cycles = 0;
    while (received < NUM_REQ && cycles < MAX_CYCLES) begin
      run_cycle();
      cycles++;
    end
    if (received < NUM_REQ) begin
      failures++;
      $display("timeout: only %0d of %0d responses after %0d cycles", received, NUM_REQ, cycles);
    end
    // Quiet tail, any late response is an extra one
    repeat (20) run_cycle();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+source
+incdir+dv
source/x86_isa_pkg.sv
source/opnd_pipe_pkg.sv
source/opnd_link.sv
source/opnd_field_extract.sv
source/opnd_source_select.sv
source/opnd_addr_resolve.sv
source/opnd_decode_top.sv
dv/tb_opnd_decode.sv
